// ==== flist.f ====
logcmp_pkg.sv
logcmp_regfile.sv
logcmp_execute.sv
logcmp_issue_buffer.sv
logcmp_dispatch.sv
logcmp_issue.sv
logcmp_top.sv
logcmp_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module logcmp_tb -f flist.f -o sim_logcmp || exit 1
./obj_dir/sim_logcmp > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// ==== logcmp_tb.sv ====
/*
 Testbench for the logic-and-compare issue cluster: runs an instruction
 table through dispatch and checks every write-back against a model
*/
`timescale 1ns/10ps

module logcmp_tb import logcmp_pkg::*; ();

	localparam int TABLE_LEN  = 40;
	localparam int CLK_PERIOD = 40;

	logic          CLK;
	logic          arst_n;
	logic          dispatch_valid;
	logcmp_instr_t dispatch_instr;
	logic          dispatch_ready;
	logic          wb_valid;
	logcmp_wb_t    wb;

	logcmp_instr_t program_tbl [TABLE_LEN];
	xlen_t         model_regs [NUM_XREGS];
	xlen_t         exp_q [NUM_XREGS][$];    // expected results for each rd in program order
	logic [31:0]   lcg_state;
	int            accept_count;
	int            wb_count;
	logic          stall_seen;

	logcmp_top u_logcmp_top (
		.CLK            (CLK),
		.arst_n         (arst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_instr (dispatch_instr),
		.dispatch_ready (dispatch_ready),
		.wb_valid       (wb_valid),
		.wb             (wb)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) CLK = ~CLK;
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic xlen_t sext12(logic [11:0] v);
		return {{(XLEN-12){v[11]}}, v};
	endfunction

	function automatic xlen_t rand_imm();
		logic [31:0] r;
		r = next_rand();
		return sext12(r[27:16]);    // upper bits of an LCG are the better ones
	endfunction

	function automatic logcmp_instr_t make_instr(logcmp_op_t op, reg_idx_t rd,
		reg_idx_t rs1, reg_idx_t rs2, xlen_t imm);
		logcmp_instr_t ins;
		ins.op  = op;
		ins.rd  = rd;
		ins.rs1 = rs1;
		ins.rs2 = rs2;
		ins.imm = imm;
		return ins;
	endfunction

	function automatic logic reads_rs2(logcmp_op_t op);
		case (op)
			OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND: return 1'b1;
			default:                                return 1'b0;
		endcase
	endfunction

	// the signed order is decided by the sign bits first
	function automatic xlen_t ref_result(logcmp_op_t op, xlen_t a, xlen_t b);
		xlen_t r;
		case (op)
			OP_SLTI, OP_SLT:   r = xlen_t'((a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b));
			OP_SLTIU, OP_SLTU: r = xlen_t'(a < b);
			OP_XORI, OP_XOR:   r = a ^ b;
			OP_ORI, OP_OR:     r = a | b;
			default:           r = a & b;
		endcase
		return r;
	endfunction

	task automatic build_program();
		program_tbl[0]  = make_instr(OP_XORI,  5'd1,  5'd0,  5'd0,  rand_imm());
		program_tbl[1]  = make_instr(OP_ORI,   5'd2,  5'd0,  5'd0,  rand_imm());
		program_tbl[2]  = make_instr(OP_XORI,  5'd3,  5'd0,  5'd0,  sext12(12'hfff));
		program_tbl[3]  = make_instr(OP_ANDI,  5'd4,  5'd3,  5'd0,  rand_imm());
		program_tbl[4]  = make_instr(OP_XORI,  5'd5,  5'd0,  5'd0,  rand_imm());
		program_tbl[5]  = make_instr(OP_ORI,   5'd6,  5'd0,  5'd0,  sext12(12'h7ff));
		program_tbl[6]  = make_instr(OP_XORI,  5'd7,  5'd0,  5'd0,  sext12(12'h800));
		program_tbl[7]  = make_instr(OP_XOR,   5'd8,  5'd1,  5'd2,  '0);
		program_tbl[8]  = make_instr(OP_OR,    5'd9,  5'd8,  5'd5,  '0);
		program_tbl[9]  = make_instr(OP_AND,   5'd10, 5'd9,  5'd3,  '0);
		program_tbl[10] = make_instr(OP_XOR,   5'd8,  5'd10, 5'd4,  '0);    // WAW and WAR on x8
		program_tbl[11] = make_instr(OP_OR,    5'd11, 5'd8,  5'd8,  '0);
		program_tbl[12] = make_instr(OP_AND,   5'd12, 5'd11, 5'd6,  '0);
		program_tbl[13] = make_instr(OP_XORI,  5'd12, 5'd12, 5'd0,  rand_imm());    // reads its own rd
		program_tbl[14] = make_instr(OP_SLT,   5'd14, 5'd7,  5'd6,  '0);
		program_tbl[15] = make_instr(OP_SLTU,  5'd15, 5'd7,  5'd6,  '0);
		program_tbl[16] = make_instr(OP_SLTI,  5'd16, 5'd3,  5'd0,  '0);
		program_tbl[17] = make_instr(OP_SLTIU, 5'd17, 5'd3,  5'd0,  sext12(12'hfff));
		program_tbl[18] = make_instr(OP_SLTIU, 5'd18, 5'd0,  5'd0,  sext12(12'h001));
		program_tbl[19] = make_instr(OP_SLTI,  5'd19, 5'd6,  5'd0,  sext12(12'h800));
		program_tbl[20] = make_instr(OP_SLT,   5'd20, 5'd6,  5'd7,  '0);
		program_tbl[21] = make_instr(OP_SLTU,  5'd21, 5'd6,  5'd7,  '0);
		program_tbl[22] = make_instr(OP_SLTIU, 5'd22, 5'd6,  5'd0,  sext12(12'h800));
		program_tbl[23] = make_instr(OP_SLT,   5'd23, 5'd3,  5'd3,  '0);
		program_tbl[24] = make_instr(OP_OR,    5'd24, 5'd21, 5'd20, '0);
		program_tbl[25] = make_instr(OP_AND,   5'd25, 5'd24, 5'd24, '0);
		program_tbl[26] = make_instr(OP_XOR,   5'd26, 5'd25, 5'd21, '0);
		program_tbl[27] = make_instr(OP_ORI,   5'd27, 5'd0,  5'd0,  rand_imm());
		program_tbl[28] = make_instr(OP_ANDI,  5'd28, 5'd1,  5'd0,  rand_imm());
		program_tbl[29] = make_instr(OP_XORI,  5'd29, 5'd2,  5'd0,  rand_imm());
		program_tbl[30] = make_instr(OP_ORI,   5'd30, 5'd5,  5'd0,  rand_imm());
		program_tbl[31] = make_instr(OP_XORI,  5'd27, 5'd28, 5'd0,  rand_imm());
		program_tbl[32] = make_instr(OP_OR,    5'd1,  5'd26, 5'd27, '0);
		program_tbl[33] = make_instr(OP_XORI,  5'd0,  5'd3,  5'd0,  sext12(12'h005));
		program_tbl[34] = make_instr(OP_SLTU,  5'd30, 5'd0,  5'd3,  '0);
		program_tbl[35] = make_instr(OP_ORI,   5'd0,  5'd6,  5'd0,  rand_imm());
		program_tbl[36] = make_instr(OP_OR,    5'd31, 5'd0,  5'd0,  '0);
		program_tbl[37] = make_instr(OP_XOR,   5'd29, 5'd0,  5'd6,  '0);
		program_tbl[38] = make_instr(OP_AND,   5'd2,  5'd3,  5'd0,  '0);
		program_tbl[39] = make_instr(OP_SLT,   5'd31, 5'd7,  5'd0,  '0);
	endtask

	task automatic run_model();
		xlen_t a;
		xlen_t b;
		xlen_t r;
		for (int i = 0; i < NUM_XREGS; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < TABLE_LEN; i++) begin
			a = model_regs[program_tbl[i].rs1];
			b = reads_rs2(program_tbl[i].op) ? model_regs[program_tbl[i].rs2] : program_tbl[i].imm;
			r = ref_result(program_tbl[i].op, a, b);
			exp_q[program_tbl[i].rd].push_back(r);
			if (program_tbl[i].rd != '0) begin
				model_regs[program_tbl[i].rd] = r;
			end
		end
	endtask

	task automatic stop_on_failure(string why);
		$display("=== FAIL ===");
		$fatal(1, "%s", why);
	endtask

	task automatic check_wb(logcmp_wb_t got, logcmp_wb_t exp);
		if (got !== exp) begin
			$display("ERROR wb: got rd=%h data=%h, expected rd=%h data=%h",
				got.rd, got.data, exp.rd, exp.data);
			stop_on_failure("write-back value mismatch");
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			stop_on_failure("control signal mismatch");
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			stop_on_failure("count mismatch");
		end
	endtask

	task automatic match_writeback(logcmp_wb_t got);
		logcmp_wb_t exp;
		int         hit;
		hit = 0;
		if (exp_q[got.rd].size() == 0) begin
			stop_on_failure("a write-back arrived with no result left to expect for its rd");
		end else begin
			// x0 is never marked busy, so two x0 writes may pass each other
			if (got.rd == '0) begin
				for (int k = exp_q[0].size() - 1; k >= 0; k--) begin
					if (exp_q[0][k] == got.data) begin
						hit = k;
					end
				end
			end
			exp.rd   = got.rd;
			exp.data = exp_q[got.rd][hit];
			exp_q[got.rd].delete(hit);
			check_wb(got, exp);
		end
	endtask

	task automatic watch_writebacks();
		forever begin
			@(negedge CLK);
			if (wb_valid) begin
				wb_count++;
				match_writeback(wb);
			end
		end
	endtask

	initial begin
		#(TABLE_LEN * 20 * CLK_PERIOD);
		stop_on_failure("timeout, the write-backs did not all arrive in time");
	end

	initial begin
		logic accepted;
		int   leftover;
		accept_count   = 0;
		wb_count       = 0;
		stall_seen     = 1'b0;
		leftover       = 0;
		lcg_state      = 32'h41c1_4711;
		arst_n         <= 1'b0;
		dispatch_valid <= 1'b0;
		dispatch_instr <= '0;
		build_program();
		run_model();
		fork
			watch_writebacks();
		join_none
		repeat (5) @(posedge CLK);
		arst_n <= 1'b1;
		@(posedge CLK);
		for (int i = 0; i < TABLE_LEN; i++) begin
			dispatch_valid <= 1'b1;
			dispatch_instr <= program_tbl[i];
			accepted = 1'b0;
			while (!accepted) begin
				@(negedge CLK);
				if (i == 0) begin
					check_bit("wb_valid", wb_valid, 1'b0);
					check_bit("dispatch_ready", dispatch_ready, 1'b1);
				end
				accepted = dispatch_ready;    // transfer happens at the coming rising edge
				if (!accepted) begin
					stall_seen = 1'b1;
				end
				@(posedge CLK);
			end
			accept_count++;
		end
		dispatch_valid <= 1'b0;
		while (wb_count < accept_count) begin
			@(negedge CLK);
		end
		repeat (4) @(negedge CLK);    // a stray extra write-back would show up here
		for (int r = 0; r < NUM_XREGS; r++) begin
			leftover += exp_q[r].size();
		end
		check_count("wb_count", wb_count, accept_count);
		check_count("leftover_results", leftover, 0);
		check_bit("dispatch_stall_seen", stall_seen, 1'b1);
		if ((wb_count == accept_count) && (leftover == 0) && stall_seen) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			stop_on_failure("end of run checks did not hold");
		end
	end

endmodule

// ==== logcmp_top.sv ====
/*
 Logic-and-compare issue cluster top level: dispatch, issue buffer, issue,
 register file and execute wired into one pipeline
*/
`timescale 1ns/10ps

module logcmp_top import logcmp_pkg::*; (
	input  logic          CLK,
	input  logic          arst_n,

	input  logic          dispatch_valid,
	input  logcmp_instr_t dispatch_instr,
	output logic          dispatch_ready,

	output logic          wb_valid,
	output logcmp_wb_t    wb
);

	logic             alloc;
	slot_idx_t        alloc_slot;
	logcmp_instr_t    alloc_instr;
	logic             pop;
	slot_idx_t        pop_slot;
	slot_vec_t        slot_valid;
	logcmp_instr_t    entries [ISSUE_DEPTH];
	reg_vec_t         busy;
	reg_idx_t         rs1_addr;
	reg_idx_t         rs2_addr;
	xlen_t            rs1_data;
	xlen_t            rs2_data;
	logic             exe_valid;
	logcmp_exeparam_t exe_param;

	logcmp_dispatch u_dispatch (
		.CLK            (CLK),
		.arst_n         (arst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_instr (dispatch_instr),
		.dispatch_ready (dispatch_ready),
		.slot_valid     (slot_valid),
		.entries        (entries),
		.alloc          (alloc),
		.alloc_slot     (alloc_slot),
		.alloc_instr    (alloc_instr),
		.wb_valid       (wb_valid),
		.wb             (wb),
		.busy           (busy)
	);

	logcmp_issue_buffer u_issue_buffer (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.alloc       (alloc),
		.alloc_slot  (alloc_slot),
		.alloc_instr (alloc_instr),
		.pop         (pop),
		.pop_slot    (pop_slot),
		.slot_valid  (slot_valid),
		.entries     (entries)
	);

	logcmp_issue u_issue (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.slot_valid (slot_valid),
		.entries    (entries),
		.busy       (busy),
		.pop        (pop),
		.pop_slot   (pop_slot),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.exe_valid  (exe_valid),
		.exe_param  (exe_param)
	);

	logcmp_regfile u_regfile (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_valid (wb_valid),
		.wb       (wb)
	);

	logcmp_execute u_execute (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.exe_valid (exe_valid),
		.exe_param (exe_param),
		.wb_valid  (wb_valid),
		.wb        (wb)
	);

endmodule

// ==== logcmp_issue.sv ====
/*
 Issue stage: picks the lowest ready buffer slot, reads its operands
 and registers the execute parameters
*/
`timescale 1ns/10ps

module logcmp_issue import logcmp_pkg::*; (
	input  logic             CLK,
	input  logic             arst_n,

	input  slot_vec_t        slot_valid,
	input  logcmp_instr_t    entries [ISSUE_DEPTH],
	input  reg_vec_t         busy,

	output logic             pop,
	output slot_idx_t        pop_slot,

	output reg_idx_t         rs1_addr,
	output reg_idx_t         rs2_addr,
	input  xlen_t            rs1_data,
	input  xlen_t            rs2_data,

	output logic             exe_valid,
	output logcmp_exeparam_t exe_param
);

	slot_vec_t        slot_ready;
	logcmp_instr_t    sel_instr;
	logcmp_exeparam_t param_d;

	function automatic logcmp_fun_t op_fun(logcmp_op_t op);
		logcmp_fun_t fun;
		case (op)
			OP_SLTI, OP_SLTIU, OP_SLT, OP_SLTU: fun = FUN_SLT;
			OP_XORI, OP_XOR:                    fun = FUN_XOR;
			OP_ORI, OP_OR:                      fun = FUN_OR;
			default:                            fun = FUN_AND;
		endcase
		return fun;
	endfunction

	// An entry's own rd is busy because of the entry itself. Dispatch let it in
	// with rd clear, so a source equal to rd already holds its final value
	function automatic logic src_ready(reg_idx_t src, reg_idx_t rd, reg_vec_t sb);
		return !sb[src] || (src == rd);
	endfunction

	always_comb begin
		for (int i = 0; i < ISSUE_DEPTH; i++) begin
			slot_ready[i] = slot_valid[i] &
				src_ready(entries[i].rs1, entries[i].rd, busy) &
				(~op_uses_rs2(entries[i].op) | src_ready(entries[i].rs2, entries[i].rd, busy));
		end
	end

	always_comb begin
		pop      = 1'b0;
		pop_slot = '0;
		for (int i = ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (slot_ready[i]) begin
				pop      = 1'b1;
				pop_slot = slot_idx_t'(i);    // lowest index ends up winning
			end
		end
	end

	assign sel_instr = entries[pop_slot];
	assign rs1_addr  = sel_instr.rs1;
	assign rs2_addr  = sel_instr.rs2;

	always_comb begin
		param_d.fun         = op_fun(sel_instr.op);
		param_d.is_unsigned = sel_instr.op inside {OP_SLTIU, OP_SLTU};
		param_d.rd          = sel_instr.rd;
		param_d.op1         = rs1_data;
		param_d.op2         = op_uses_rs2(sel_instr.op) ? rs2_data : sel_instr.imm;
	end

	// execute accepts every cycle, so whatever is picked is popped
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			exe_param <= param_d;
		end
	end

endmodule

// ==== logcmp_dispatch.sv ====
/*
 Dispatch stage: holds the busy scoreboard, stalls on WAW and WAR hazards
 and allocates the lowest free issue buffer slot
*/
`timescale 1ns/10ps

module logcmp_dispatch import logcmp_pkg::*; (
	input  logic          CLK,
	input  logic          arst_n,

	input  logic          dispatch_valid,
	input  logcmp_instr_t dispatch_instr,
	output logic          dispatch_ready,

	input  slot_vec_t     slot_valid,
	input  logcmp_instr_t entries [ISSUE_DEPTH],

	output logic          alloc,
	output slot_idx_t     alloc_slot,
	output logcmp_instr_t alloc_instr,

	input  logic          wb_valid,
	input  logcmp_wb_t    wb,

	output reg_vec_t      busy
);

	logic      has_free;
	slot_idx_t free_slot;
	logic      rd_busy;
	slot_vec_t war_hit;
	reg_vec_t  busy_q;

	always_comb begin
		has_free  = 1'b0;
		free_slot = '0;
		for (int i = ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (!slot_valid[i]) begin
				has_free  = 1'b1;
				free_slot = slot_idx_t'(i);
			end
		end
	end

	// a waiting entry must still see the old value of anything it reads
	always_comb begin
		for (int i = 0; i < ISSUE_DEPTH; i++) begin
			war_hit[i] = slot_valid[i] & (
				(entries[i].rs1 == dispatch_instr.rd) |
				(op_uses_rs2(entries[i].op) & (entries[i].rs2 == dispatch_instr.rd)));
		end
	end

	assign rd_busy = busy_q[dispatch_instr.rd];    // x0 never reads as busy

	assign dispatch_ready = has_free & ~rd_busy & ~(|war_hit);

	assign alloc       = dispatch_valid & dispatch_ready;
	assign alloc_slot  = free_slot;
	assign alloc_instr = dispatch_instr;

	// set after clear, so a same-cycle set of the same register wins
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= '0;
		end else begin
			if (wb_valid) begin
				busy_q[wb.rd] <= 1'b0;
			end
			if (alloc && (dispatch_instr.rd != '0)) begin
				busy_q[dispatch_instr.rd] <= 1'b1;
			end
		end
	end

	assign busy = busy_q;

endmodule

// ==== logcmp_issue_buffer.sv ====
/*
 Issue buffer: ISSUE_DEPTH waiting instruction records with a valid bit
 per slot, filled by dispatch and freed by issue
*/
`timescale 1ns/10ps

module logcmp_issue_buffer import logcmp_pkg::*; (
	input  logic          CLK,
	input  logic          arst_n,

	input  logic          alloc,
	input  slot_idx_t     alloc_slot,
	input  logcmp_instr_t alloc_instr,

	input  logic          pop,
	input  slot_idx_t     pop_slot,

	output slot_vec_t     slot_valid,
	output logcmp_instr_t entries [ISSUE_DEPTH]
);

	slot_vec_t     valid_q;
	logcmp_instr_t mem_q [ISSUE_DEPTH];

	// dispatch only allocates free slots, so alloc and pop never collide
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else begin
			if (pop) begin
				valid_q[pop_slot] <= 1'b0;
			end
			if (alloc) begin
				valid_q[alloc_slot] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (alloc) begin
			mem_q[alloc_slot] <= alloc_instr;
		end
	end

	assign slot_valid = valid_q;

	always_comb begin
		for (int i = 0; i < ISSUE_DEPTH; i++) begin
			entries[i] = mem_q[i];
		end
	end

endmodule

// ==== logcmp_execute.sv ====
/*
 Execute unit: signed or unsigned set-less-than and bitwise XOR, OR, AND,
 result registered together with rd for write-back
*/
`timescale 1ns/10ps

module logcmp_execute import logcmp_pkg::*; (
	input  logic             CLK,
	input  logic             arst_n,

	input  logic             exe_valid,
	input  logcmp_exeparam_t exe_param,

	output logic             wb_valid,
	output logcmp_wb_t       wb
);

	logic  less;
	xlen_t result;

	always_comb begin
		if (exe_param.is_unsigned) begin
			less = exe_param.op1 < exe_param.op2;
		end else begin
			less = $signed(exe_param.op1) < $signed(exe_param.op2);
		end
	end

	always_comb begin
		case (exe_param.fun)
			FUN_SLT: result = xlen_t'(less);    // zero-extended 0 or 1
			FUN_XOR: result = exe_param.op1 ^ exe_param.op2;
			FUN_OR:  result = exe_param.op1 | exe_param.op2;
			default: result = exe_param.op1 & exe_param.op2;
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			wb.rd   <= exe_param.rd;
			wb.data <= result;
		end
	end

endmodule

// ==== logcmp_regfile.sv ====
/*
 Integer register file, 32 x 64 bits, two combinational read ports,
 one write port from write-back, x0 hard-wired to zero
*/
`timescale 1ns/10ps

module logcmp_regfile import logcmp_pkg::*; (
	input  logic       CLK,
	input  logic       arst_n,

	input  reg_idx_t   rs1_addr,
	input  reg_idx_t   rs2_addr,
	output xlen_t      rs1_data,
	output xlen_t      rs2_data,

	input  logic       wb_valid,
	input  logcmp_wb_t wb
);

	xlen_t regs_q [1:NUM_XREGS-1];

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < NUM_XREGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wb_valid && (wb.rd != '0)) begin
			regs_q[wb.rd] <= wb.data;
		end
	end

	// issue waits for busy to clear, so a same-cycle write is never read here
	assign rs1_data = (rs1_addr == '0) ? '0 : regs_q[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs_q[rs2_addr];

endmodule

// ==== logcmp_pkg.sv ====
/*
 Logic-and-compare issue cluster: shared widths, opcodes, buffer depth
 and the records passed between dispatch, issue, execute and write-back
*/
package logcmp_pkg;

	localparam int XLEN        = 64;
	localparam int NUM_XREGS   = 32;
	localparam int ISSUE_DEPTH = 4;

	typedef logic [XLEN-1:0]                xlen_t;
	typedef logic [$clog2(NUM_XREGS)-1:0]   reg_idx_t;
	typedef logic [NUM_XREGS-1:0]           reg_vec_t;    // one bit per architectural register
	typedef logic [$clog2(ISSUE_DEPTH)-1:0] slot_idx_t;
	typedef logic [ISSUE_DEPTH-1:0]         slot_vec_t;

	typedef logic [3:0] logcmp_op_t;

	localparam logcmp_op_t OP_SLTI  = 4'd0;
	localparam logcmp_op_t OP_SLTIU = 4'd1;
	localparam logcmp_op_t OP_SLT   = 4'd2;
	localparam logcmp_op_t OP_SLTU  = 4'd3;
	localparam logcmp_op_t OP_XORI  = 4'd4;
	localparam logcmp_op_t OP_XOR   = 4'd5;
	localparam logcmp_op_t OP_ORI   = 4'd6;
	localparam logcmp_op_t OP_OR    = 4'd7;
	localparam logcmp_op_t OP_ANDI  = 4'd8;
	localparam logcmp_op_t OP_AND   = 4'd9;

	typedef logic [1:0] logcmp_fun_t;

	localparam logcmp_fun_t FUN_SLT = 2'd0;
	localparam logcmp_fun_t FUN_XOR = 2'd1;
	localparam logcmp_fun_t FUN_OR  = 2'd2;
	localparam logcmp_fun_t FUN_AND = 2'd3;

	typedef struct packed {
		logcmp_op_t op;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		xlen_t      imm;    // already sign-extended by the decoder
	} logcmp_instr_t;

	typedef struct packed {
		logcmp_fun_t fun;
		logic        is_unsigned;
		reg_idx_t    rd;
		xlen_t       op1;
		xlen_t       op2;
	} logcmp_exeparam_t;

	typedef struct packed {
		reg_idx_t rd;
		xlen_t    data;
	} logcmp_wb_t;

	// register-register forms read rs2, the immediate forms do not
	function automatic logic op_uses_rs2(logcmp_op_t op);
		return op inside {OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND};
	endfunction

endpackage
